// ==== compile.f ====
+incdir+logic
logic/cp0_pkg.sv
logic/cp0_timer.sv
logic/cp0_exception.sv
logic/cp0_regs.sv
logic/cp0_top.sv
tb/tb_clock.sv
tb/cp0_tb.sv

// ==== logic/cp0_exception.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cp0_settings.svh"

module cp0_exception (
    input  cp0_pkg::cp0_except_t  exc_i,
    input  wire                   exl_i,
    output cp0_pkg::exc_update_t  update_o
);

    logic                    is_int;
    logic                    is_addr_err;
    logic [`CP0_DATA_W-1:0]  victim_pc;

    assign is_int      = (exc_i.kind == cp0_pkg::EXC_INT);
    assign is_addr_err = (exc_i.kind == cp0_pkg::EXC_ADEL) ||
                         (exc_i.kind == cp0_pkg::EXC_ADES);

    // restart address is the branch when in a delay slot
    assign victim_pc = exc_i.in_delay_slot ? exc_i.pc - `CP0_EPC_BD_OFFSET : exc_i.pc;

    always_comb begin
        update_o          = '0;
        update_o.epc      = victim_pc;
        update_o.bd       = exc_i.in_delay_slot;
        update_o.badvaddr = exc_i.bad_vaddr;

        case (exc_i.kind)
            cp0_pkg::EXC_INT: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_INT;
            end
            cp0_pkg::EXC_ADEL: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_ADEL;
            end
            cp0_pkg::EXC_ADES: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_ADES;
            end
            cp0_pkg::EXC_SYSCALL: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_SYS;
            end
            cp0_pkg::EXC_BREAK: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_BP;
            end
            cp0_pkg::EXC_RI: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_RI;
            end
            cp0_pkg::EXC_OV: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_OV;
            end
            cp0_pkg::EXC_TRAP: begin
                update_o.enter = 1'b1;
                update_o.code  = cp0_pkg::CODE_TR;
            end
            cp0_pkg::EXC_ERET: begin
                update_o.leave = 1'b1;
            end
            default: begin
                update_o.enter = 1'b0;   // none or unknown
            end
        endcase

        // nested exceptions keep the first EPC but interrupts always reload it
        update_o.load_epc      = update_o.enter && (!exl_i || is_int);
        update_o.load_badvaddr = is_addr_err;
    end

endmodule

`default_nettype wire

// ==== logic/cp0_pkg.sv ====
`default_nettype none

`include "cp0_settings.svh"

package cp0_pkg;

    typedef enum logic [4:0] {
        CP0_BADVADDR = 5'd8,
        CP0_COUNT    = 5'd9,
        CP0_COMPARE  = 5'd11,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14,
        CP0_PRID     = 5'd15,
        CP0_CONFIG   = 5'd16
    } cp0_addr_e;

    // exception kind as delivered by the pipeline
    typedef enum logic [4:0] {
        EXC_NONE    = 5'd0,
        EXC_INT     = 5'd1,
        EXC_ADEL    = 5'd4,
        EXC_ADES    = 5'd5,
        EXC_SYSCALL = 5'd8,
        EXC_BREAK   = 5'd9,
        EXC_RI      = 5'd10,
        EXC_OV      = 5'd12,
        EXC_TRAP    = 5'd13,
        EXC_ERET    = 5'd14
    } exc_type_e;

    // ExcCode field of Cause
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12,
        CODE_TR   = 5'd13
    } exc_code_e;

    typedef struct packed {
        logic                    we;
        cp0_addr_e               addr;
        logic [2:0]              sel;
        logic [`CP0_DATA_W-1:0]  data;
    } cp0_write_t;

    typedef struct packed {
        exc_type_e               kind;
        logic [`CP0_DATA_W-1:0]  pc;
        logic [`CP0_DATA_W-1:0]  bad_vaddr;
        logic                    in_delay_slot;
    } cp0_except_t;

    typedef struct packed {
        logic                    enter;   // set EXL, write ExcCode
        logic                    leave;   // eret
        logic                    load_epc;
        logic [`CP0_DATA_W-1:0]  epc;
        logic                    bd;
        exc_code_e               code;
        logic                    load_badvaddr;
        logic [`CP0_DATA_W-1:0]  badvaddr;
    } exc_update_t;

endpackage

`default_nettype wire

// ==== logic/cp0_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cp0_settings.svh"

module cp0_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       hold_i,
    input  cp0_pkg::cp0_write_t       wr_i,
    input  cp0_pkg::exc_update_t      update_i,
    input  wire [`CP0_INT_W-1:0]      int_i,
    input  wire [`CP0_DATA_W-1:0]     count_i,
    input  wire [`CP0_DATA_W-1:0]     compare_i,
    input  cp0_pkg::cp0_addr_e        raddr_i,
    input  wire [2:0]                 rsel_i,
    output logic                      exl_o,
    output logic [`CP0_DATA_W-1:0]    status_o,
    output logic [`CP0_DATA_W-1:0]    cause_o,
    output logic [`CP0_DATA_W-1:0]    epc_o,
    output logic [`CP0_DATA_W-1:0]    data_o
);

    logic [`CP0_DATA_W-1:0] badvaddr_q;

    assign exl_o = status_o[`CP0_STATUS_EXL];

    always_ff @(posedge clk) begin
        if (rst) begin
            status_o   <= `CP0_STATUS_RESET;
            cause_o    <= '0;
            epc_o      <= '0;
            badvaddr_q <= '0;
        end else if (!hold_i) begin
            cause_o[15:10] <= int_i;   // hw interrupt pending bits

            if (wr_i.we) begin
                case (wr_i.addr)
                    cp0_pkg::CP0_STATUS:   status_o   <= wr_i.data;
                    cp0_pkg::CP0_EPC:      epc_o      <= wr_i.data;
                    cp0_pkg::CP0_BADVADDR: badvaddr_q <= wr_i.data;
                    cp0_pkg::CP0_CAUSE: begin   // IV, WP and the soft IP bits
                        cause_o[9:8]   <= wr_i.data[9:8];
                        cause_o[23:22] <= wr_i.data[23:22];
                    end
                    default: begin
                    end
                endcase
            end

            // exception update goes last so it overrides a same-edge write
            if (update_i.enter) begin
                status_o[`CP0_STATUS_EXL] <= 1'b1;
                cause_o[6:2]              <= update_i.code;
            end
            if (update_i.leave) begin
                status_o[`CP0_STATUS_EXL] <= 1'b0;
            end
            if (update_i.load_epc) begin
                epc_o                 <= update_i.epc;
                cause_o[`CP0_CAUSE_BD] <= update_i.bd;
            end
            if (update_i.load_badvaddr) begin
                badvaddr_q <= update_i.badvaddr;
            end
        end
    end

    // read port
    always_comb begin
        case (raddr_i)
            cp0_pkg::CP0_BADVADDR: data_o = badvaddr_q;
            cp0_pkg::CP0_COUNT:    data_o = count_i;
            cp0_pkg::CP0_COMPARE:  data_o = compare_i;
            cp0_pkg::CP0_STATUS:   data_o = status_o;
            cp0_pkg::CP0_CAUSE:    data_o = cause_o;
            cp0_pkg::CP0_EPC:      data_o = epc_o;
            cp0_pkg::CP0_PRID: begin
                data_o = (rsel_i == 3'd0) ? `CP0_PRID_VALUE : '0;
            end
            cp0_pkg::CP0_CONFIG: begin
                data_o = (rsel_i == 3'd0) ? `CP0_CONFIG0_VALUE : '0;
            end
            default:               data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cp0_settings.svh ====
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// register and bus widths
`define CP0_DATA_W 32
`define CP0_INT_W 6

// CU0 set and EXL clear after reset
`define CP0_STATUS_RESET 32'h1000_0000

// fixed identification registers
`define CP0_PRID_VALUE 32'h0000_4220
`define CP0_CONFIG0_VALUE 32'h8000_0083   // M bit, MT=1, K0=3

// EPC points back at the branch for a delay-slot exception
`define CP0_EPC_BD_OFFSET 32'd4

// Status and Cause field positions
`define CP0_STATUS_EXL 1
`define CP0_CAUSE_BD 31

`endif

// ==== logic/cp0_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cp0_settings.svh"

module cp0_timer (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       hold_i,
    input  cp0_pkg::cp0_write_t       wr_i,
    output logic [`CP0_DATA_W-1:0]    count_o,
    output logic [`CP0_DATA_W-1:0]    compare_o,
    output logic                      timer_int_o
);

    logic tick;
    logic count_we;
    logic compare_we;
    logic match;

    assign count_we   = wr_i.we && (wr_i.addr == cp0_pkg::CP0_COUNT);
    assign compare_we = wr_i.we && (wr_i.addr == cp0_pkg::CP0_COMPARE);
    assign match      = (compare_o != '0) && (count_o == compare_o);

    // half-rate tick that keeps toggling through hold
    always_ff @(posedge clk) begin
        if (rst) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_o     <= '0;
            compare_o   <= '0;
            timer_int_o <= 1'b0;
        end else if (!hold_i) begin
            if (count_we) begin
                count_o <= wr_i.data;      // software write beats the tick
            end else if (tick) begin
                count_o <= count_o + 1'b1;
            end

            if (compare_we) begin
                compare_o   <= wr_i.data;
                timer_int_o <= 1'b0;       // ack of the timer interrupt
            end else if (match) begin
                timer_int_o <= 1'b1;       // sticky
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cp0_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cp0_settings.svh"

module cp0_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       hold_i,
    input  cp0_pkg::cp0_write_t       wr_i,
    input  cp0_pkg::cp0_except_t      exc_i,
    input  wire [`CP0_INT_W-1:0]      int_i,
    input  cp0_pkg::cp0_addr_e        raddr_i,
    input  wire [2:0]                 rsel_i,
    output logic [`CP0_DATA_W-1:0]    data_o,
    output logic [`CP0_DATA_W-1:0]    status_o,
    output logic [`CP0_DATA_W-1:0]    cause_o,
    output logic [`CP0_DATA_W-1:0]    epc_o,
    output logic                      timer_int_o
);

    logic                   exl;
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;
    cp0_pkg::exc_update_t   update;

    cp0_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .hold_i      (hold_i),
        .wr_i        (wr_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_exception u_exception (
        .exc_i    (exc_i),
        .exl_i    (exl),
        .update_o (update)
    );

    cp0_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .hold_i    (hold_i),
        .wr_i      (wr_i),
        .update_i  (update),
        .int_i     (int_i),
        .count_i   (count),
        .compare_i (compare),
        .raddr_i   (raddr_i),
        .rsel_i    (rsel_i),
        .exl_o     (exl),
        .status_o  (status_o),
        .cause_o   (cause_o),
        .epc_o     (epc_o),
        .data_o    (data_o)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the CP0 testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module cp0_tb \
    -Mdir obj_dir -o cp0_sim \
    && ./obj_dir/cp0_sim | tee /dev/stderr \
    | grep "Simulation completed successfully" > /dev/null \
    && echo "result: PASS" \
    || { echo "result: FAIL"; exit 1; }

exit 0

// ==== tb/cp0_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cp0_settings.svh"

module cp0_tb;

    localparam int MAX_WAIT = 10;

    typedef enum logic [3:0] {
        OP_WRITE, OP_CMP_REL, OP_EXC, OP_READ, OP_SNAP, OP_DELTA,
        OP_TIMER, OP_WAIT, OP_HOLD, OP_INT
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  addr;      // register address or exception kind
        logic [2:0]  sel;
        logic [31:0] data;      // write data, pc or wait count
        logic [31:0] aux;       // bad vaddr
        logic        slot;
        logic [31:0] mask;
        logic [31:0] exp_val;
    } step_t;

    logic                  clk;
    logic                  rst;
    logic                  hold_i;
    cp0_pkg::cp0_write_t   wr_i;
    cp0_pkg::cp0_except_t  exc_i;
    logic [`CP0_INT_W-1:0] int_i;
    cp0_pkg::cp0_addr_e    raddr_i;
    logic [2:0]            rsel_i;
    logic [31:0]           data_o;
    logic [31:0]           status_o;
    logic [31:0]           cause_o;
    logic [31:0]           epc_o;
    logic                  timer_int_o;

    step_t       steps[$];
    string       names[$];
    logic [31:0] snap;       // count seen by the last sample step
    logic        built;
    int          n_pass;
    int          n_fail;

    tb_clock clock_gen (.clk_o(clk), .rst_o(rst));

    cp0_top uut (
        .clk         (clk),
        .rst         (rst),
        .hold_i      (hold_i),
        .wr_i        (wr_i),
        .exc_i       (exc_i),
        .int_i       (int_i),
        .raddr_i     (raddr_i),
        .rsel_i      (rsel_i),
        .data_o      (data_o),
        .status_o    (status_o),
        .cause_o     (cause_o),
        .epc_o       (epc_o),
        .timer_int_o (timer_int_o)
    );

    function automatic logic [31:0] cause_word(input logic bd, input logic [4:0] code,
                                               input logic [31:0] sw);
        cause_word = {bd, 31'd0} | {25'd0, code, 2'b00} | sw;
    endfunction

    task automatic add_step(input op_e op, input string name, input logic [4:0] addr = 5'd0,
                            input logic [31:0] data = 32'd0, input logic [31:0] exp_val = 32'd0,
                            input logic [31:0] mask = 32'hffff_ffff, input logic [2:0] sel = 3'd0,
                            input logic [31:0] aux = 32'd0, input logic slot = 1'b0);
        steps.push_back({op, addr, sel, data, aux, slot, mask, exp_val});
        names.push_back(name);
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act);
        if (act !== exp_val) begin
            $display("** Error: %s expected %h actual %h", name, exp_val, act);
            n_fail++;
        end else begin
            $display("ok: %s", name);
            n_pass++;
        end
    endtask

    // status, cause and epc also come out on their own ports
    task automatic check_ports(input step_t s, input string name);
        logic [31:0] exp_val;
        exp_val = s.exp_val & s.mask;
        case (s.addr)
            cp0_pkg::CP0_STATUS: begin
                compare_value({name, " on status_o"}, exp_val, status_o & s.mask);
            end
            cp0_pkg::CP0_CAUSE: begin
                compare_value({name, " on cause_o"}, exp_val, cause_o & s.mask);
            end
            cp0_pkg::CP0_EPC: begin
                compare_value({name, " on epc_o"}, exp_val, epc_o & s.mask);
            end
            default: begin
            end
        endcase
    endtask

    task automatic build_table();
        logic [31:0] rnd [10];
        logic [31:0] sw;
        logic [5:0]  irq;
        foreach (rnd[i]) begin
            rnd[i] = $urandom;
        end
        for (int i = 4; i < 8; i++) begin
            rnd[i][1:0] = 2'b00;   // word-aligned pcs
        end
        sw  = rnd[3] & 32'h00C0_0300;
        irq = 6'($urandom_range(63, 1));

        // count goes first since it is only 0 on the first edge out of reset
        add_step(OP_READ, "count after reset", cp0_pkg::CP0_COUNT);
        add_step(OP_READ, "compare after reset", cp0_pkg::CP0_COMPARE);
        add_step(OP_TIMER, "timer interrupt after reset");
        add_step(OP_READ, "status after reset", cp0_pkg::CP0_STATUS, 0, `CP0_STATUS_RESET);
        add_step(OP_READ, "prid", cp0_pkg::CP0_PRID, 0, `CP0_PRID_VALUE);
        add_step(OP_READ, "config", cp0_pkg::CP0_CONFIG, 0, `CP0_CONFIG0_VALUE);
        add_step(OP_READ, "epc after reset", cp0_pkg::CP0_EPC);
        add_step(OP_READ, "cause after reset", cp0_pkg::CP0_CAUSE);
        add_step(OP_READ, "badvaddr after reset", cp0_pkg::CP0_BADVADDR);
        add_step(OP_READ, "prid select 1", cp0_pkg::CP0_PRID, 0, 0, 32'hffff_ffff, 3'd1);
        add_step(OP_READ, "unlisted address", 5'd3);

        add_step(OP_WRITE, "write status", cp0_pkg::CP0_STATUS, rnd[0]);
        add_step(OP_READ, "status read back", cp0_pkg::CP0_STATUS, 0, rnd[0]);
        add_step(OP_WRITE, "write epc", cp0_pkg::CP0_EPC, rnd[1]);
        add_step(OP_READ, "epc read back", cp0_pkg::CP0_EPC, 0, rnd[1]);
        add_step(OP_WRITE, "write badvaddr", cp0_pkg::CP0_BADVADDR, rnd[2]);
        add_step(OP_READ, "badvaddr read back", cp0_pkg::CP0_BADVADDR, 0, rnd[2]);
        add_step(OP_WRITE, "write cause", cp0_pkg::CP0_CAUSE, rnd[3]);
        add_step(OP_READ, "cause write mask", cp0_pkg::CP0_CAUSE, 0, sw);
        add_step(OP_WRITE, "restore status", cp0_pkg::CP0_STATUS, `CP0_STATUS_RESET);

        add_step(OP_EXC, "syscall", cp0_pkg::EXC_SYSCALL, rnd[4]);
        add_step(OP_READ, "epc after syscall", cp0_pkg::CP0_EPC, 0, rnd[4]);
        add_step(OP_READ, "cause after syscall", cp0_pkg::CP0_CAUSE, 0, cause_word(0, 8, sw));
        add_step(OP_READ, "exl set", cp0_pkg::CP0_STATUS, 0, `CP0_STATUS_RESET | 32'h2);
        add_step(OP_EXC, "nested break", cp0_pkg::EXC_BREAK, rnd[5]);
        add_step(OP_READ, "epc kept", cp0_pkg::CP0_EPC, 0, rnd[4]);
        add_step(OP_READ, "cause after break", cp0_pkg::CP0_CAUSE, 0, cause_word(0, 9, sw));
        add_step(OP_EXC, "eret 1", cp0_pkg::EXC_ERET);
        add_step(OP_READ, "exl cleared", cp0_pkg::CP0_STATUS, 0, `CP0_STATUS_RESET);
        add_step(OP_EXC, "overflow in slot", cp0_pkg::EXC_OV, rnd[6], 0, 0, 0, 0, 1'b1);
        add_step(OP_READ, "epc in slot", cp0_pkg::CP0_EPC, 0, rnd[6] - 32'd4);
        add_step(OP_READ, "cause in slot", cp0_pkg::CP0_CAUSE, 0, cause_word(1, 12, sw));
        add_step(OP_EXC, "eret 2", cp0_pkg::EXC_ERET);
        add_step(OP_EXC, "load address error", cp0_pkg::EXC_ADEL, rnd[7], 0, 0, 0, rnd[8]);
        add_step(OP_READ, "badvaddr after adel", cp0_pkg::CP0_BADVADDR, 0, rnd[8]);
        add_step(OP_READ, "epc after adel", cp0_pkg::CP0_EPC, 0, rnd[7]);
        add_step(OP_READ, "cause after adel", cp0_pkg::CP0_CAUSE, 0, cause_word(0, 4, sw));

        add_step(OP_SNAP, "count sample", cp0_pkg::CP0_COUNT);
        add_step(OP_WAIT, "wait", 0, 9);   // the read edge makes it 10
        add_step(OP_DELTA, "count half rate", cp0_pkg::CP0_COUNT, 0, 32'd5);
        add_step(OP_SNAP, "count sample", cp0_pkg::CP0_COUNT);
        add_step(OP_CMP_REL, "compare count plus 3", cp0_pkg::CP0_COMPARE, 32'd3);
        add_step(OP_WAIT, "wait", 0, MAX_WAIT);
        add_step(OP_TIMER, "timer interrupt raised", 0, 0, 32'd1);
        add_step(OP_WRITE, "write compare", cp0_pkg::CP0_COMPARE, rnd[9] | 32'h8000_0000);
        add_step(OP_TIMER, "timer interrupt cleared");

        add_step(OP_HOLD, "hold on", 0, 1);
        add_step(OP_SNAP, "count sample", cp0_pkg::CP0_COUNT);
        add_step(OP_WRITE, "epc write under hold", cp0_pkg::CP0_EPC, ~rnd[7]);
        add_step(OP_WAIT, "wait", 0, 6);
        add_step(OP_DELTA, "count frozen", cp0_pkg::CP0_COUNT);
        add_step(OP_HOLD, "hold off", 0, 0);
        add_step(OP_READ, "epc unchanged", cp0_pkg::CP0_EPC, 0, rnd[7]);

        add_step(OP_INT, "drive interrupt lines", 0, {26'd0, irq});
        add_step(OP_READ, "cause ip bits", cp0_pkg::CP0_CAUSE, 0, {16'd0, irq, 10'd0},
                 32'h0000_fc00);
    endtask

    task automatic run_step(input step_t s, input string name);
        case (s.op)
            OP_WRITE, OP_CMP_REL: begin
                @(posedge clk);
                wr_i.we   <= 1'b1;
                wr_i.addr <= cp0_pkg::cp0_addr_e'(s.addr);
                wr_i.sel  <= s.sel;
                wr_i.data <= (s.op == OP_CMP_REL) ? snap + s.data : s.data;
                @(posedge clk);
                wr_i.we   <= 1'b0;
            end
            OP_EXC: begin
                @(posedge clk);
                exc_i.kind          <= cp0_pkg::exc_type_e'(s.addr);
                exc_i.pc            <= s.data;
                exc_i.bad_vaddr     <= s.aux;
                exc_i.in_delay_slot <= s.slot;
                @(posedge clk);
                exc_i.kind <= cp0_pkg::EXC_NONE;
            end
            OP_READ, OP_SNAP, OP_DELTA: begin
                @(posedge clk);
                raddr_i <= cp0_pkg::cp0_addr_e'(s.addr);
                rsel_i  <= s.sel;
                @(negedge clk);   // read mux settled
                if (s.op == OP_READ) begin
                    compare_value(name, s.exp_val & s.mask, data_o & s.mask);
                    check_ports(s, name);
                end else if (s.op == OP_DELTA) begin
                    compare_value(name, s.exp_val, data_o - snap);
                end else begin
                    snap = data_o;
                end
            end
            OP_TIMER: begin
                @(posedge clk);
                @(negedge clk);
                compare_value(name, s.exp_val, {31'd0, timer_int_o});
            end
            OP_WAIT: begin
                repeat (s.data) @(posedge clk);
            end
            OP_HOLD: begin
                @(posedge clk);
                hold_i <= s.data[0];
            end
            default: begin
                @(posedge clk);
                int_i <= s.data[`CP0_INT_W-1:0];
            end
        endcase
    endtask

    initial begin
        wr_i    = '0;
        exc_i   = '0;
        hold_i  = 1'b0;
        int_i   = '0;
        raddr_i = cp0_pkg::CP0_STATUS;
        rsel_i  = 3'd0;
        built   = 1'b0;
        void'($urandom(32'hcfe48dcf));
        build_table();
        built = 1'b1;
        wait (rst === 1'b0);
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i], names[i]);
        end
        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // longest step is a wait while the others take two edges
    initial begin
        int limit_ns;
        wait (built === 1'b1);
        limit_ns = (steps.size() * (MAX_WAIT + 2) + 10) * 100;
        #(limit_ns);
        $display("watchdog: the tests did not finish within %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;   // released on an edge
    end

endmodule

`default_nettype wire
